/* acore_apb_regs.sv */
`include "acore_cfg.svh"

module acore_apb_regs (
    input wire logic ext_clk,
    input wire logic rst_i,

    input wire logic psel_i,
    input wire logic penable_i,
    input wire logic pwrite_i,
    input acore_pkg::paddr_t paddr_i,
    input acore_pkg::pdata_t pwdata_i,
    output acore_pkg::pdata_t prdata_o,
    output logic pready_o,
    output logic pslverr_o,

    input acore_pkg::fcount_t frame_count_i,                   // from the retimer

    output logic en_v2t_o,
    output logic [`ACORE_NTI-1:0] en_slice_o,
    output acore_pkg::ndiv_t ndiv_o,
    output logic [`ACORE_NTI*`ACORE_NIN-1:0] offset_o          // slice 0 in the low byte
);

    localparam acore_pkg::paddr_t ADDR_CTRL   = 8'h00;
    localparam acore_pkg::paddr_t ADDR_NDIV   = 8'h04;
    localparam acore_pkg::paddr_t ADDR_OFS0   = 8'h08;        // slices follow every 4 bytes
    localparam acore_pkg::paddr_t ADDR_STATUS = 8'h18;

    logic access;
    logic wr_en;
    logic hit_ctrl;
    logic hit_ndiv;
    logic hit_status;
    logic [`ACORE_NTI-1:0] hit_ofs;
    logic mapped;

    logic en_v2t_q;
    logic [`ACORE_NTI-1:0] en_slice_q;
    acore_pkg::ndiv_t ndiv_q;
    acore_pkg::offset_t offset_q [`ACORE_NTI];

    assign access = psel_i & penable_i;
    assign wr_en  = access & pwrite_i;

    // address decode
    assign hit_ctrl   = (paddr_i == ADDR_CTRL);
    assign hit_ndiv   = (paddr_i == ADDR_NDIV);
    assign hit_status = (paddr_i == ADDR_STATUS);

    always_comb begin
        for (int k = 0; k < `ACORE_NTI; k++) begin
            hit_ofs[k] = (paddr_i == acore_pkg::paddr_t'(ADDR_OFS0 + 4 * k));
        end
    end

    assign mapped = hit_ctrl | hit_ndiv | hit_status | (|hit_ofs);

    always_ff @(posedge ext_clk) begin
        if (rst_i) begin
            en_v2t_q   <= 1'b0;
            en_slice_q <= '0;
            ndiv_q     <= '0;
            for (int k = 0; k < `ACORE_NTI; k++) begin
                offset_q[k] <= '0;
            end
        end else if (wr_en) begin
            if (hit_ctrl) begin
                en_v2t_q   <= pwdata_i[0];
                en_slice_q <= pwdata_i[4 +: `ACORE_NTI];
            end
            if (hit_ndiv) begin
                ndiv_q <= pwdata_i[`ACORE_NDIV_W-1:0];
            end
            for (int k = 0; k < `ACORE_NTI; k++) begin
                if (hit_ofs[k]) begin
                    offset_q[k] <= pwdata_i[`ACORE_NIN-1:0];
                end
            end
        end
    end

    // read mux, zero for anything unmapped
    always_comb begin
        prdata_o = '0;
        if (hit_ctrl) begin
            prdata_o[0]               = en_v2t_q;
            prdata_o[4 +: `ACORE_NTI] = en_slice_q;
        end
        if (hit_ndiv) begin
            prdata_o[`ACORE_NDIV_W-1:0] = ndiv_q;
        end
        if (hit_status) begin
            prdata_o[15:0] = frame_count_i;
        end
        for (int k = 0; k < `ACORE_NTI; k++) begin
            if (hit_ofs[k]) begin
                prdata_o[`ACORE_NIN-1:0] = offset_q[k];
            end
        end
    end

    assign pready_o  = 1'b1;                                    // zero wait states
    assign pslverr_o = access & (~mapped | (pwrite_i & hit_status));

    assign en_v2t_o   = en_v2t_q;
    assign en_slice_o = en_slice_q;
    assign ndiv_o     = ndiv_q;

    always_comb begin
        for (int k = 0; k < `ACORE_NTI; k++) begin
            offset_o[k*`ACORE_NIN +: `ACORE_NIN] = offset_q[k];
        end
    end

endmodule

/* acore_cfg.svh */
`ifndef ACORE_CFG_SVH
`define ACORE_CFG_SVH

// number of time-interleaved adc slices
`define ACORE_NTI 4

// magnitude code width per slice
`define ACORE_NADC 8

// signed input sample width, also used for the offset trim
`define ACORE_NIN 8

// width of the input divider ratio
`define ACORE_NDIV_W 4

`endif

/* acore_pkg.sv */
`include "acore_cfg.svh"

package acore_pkg;

    // data path
    typedef logic signed [`ACORE_NIN-1:0] sample_t;   // input code from the front end
    typedef logic signed [`ACORE_NIN-1:0] offset_t;   // per-slice trim
    typedef logic [`ACORE_NADC-1:0] code_t;           // saturated magnitude

    // clocking
    typedef logic [`ACORE_NDIV_W-1:0] ndiv_t;

    // apb side
    typedef logic [7:0] paddr_t;
    typedef logic [31:0] pdata_t;
    typedef logic [15:0] fcount_t;

endpackage

/* acore_tests.txt */
# W addr data | R addr data err (data of 18 is checked against frames seen)
# F x0 x1 x2 x3 are signed hex samples, slice 0 first
R 00 00000000 0
R 04 00000000 0
R 08 00000000 0
R 14 00000000 0
R 18 00000000 0
R 1c 00000000 1
W 40 00000001
W 18 00000055
W 08 00000010
W 0c 000000f0
W 10 0000007f
W 14 00000080
R 0c 000000f0 0
R 14 00000080 0
W 00 000000f1
R 00 000000f1 0
F 05 05 7f 80
F f0 10 00 ff
W 14 00000001
F 80 7f 81 7f
W 00 00000000
W 04 00000003
R 04 00000003 0
W 08 00000000
W 0c 00000000
W 10 00000000
W 14 00000000
W 00 000000f1
F 11 22 33 44
W 00 00000051
F 91 22 b3 44
R 18 00000000 0
W 00 00000000
W 00 000000f1
F 01 02 03 04
R 18 00000000 0

/* adc_slice.sv */
`include "acore_cfg.svh"

module adc_slice #(
    parameter bit FIRST_SLICE = 1'b0
) (
    input wire logic ext_clk,
    input wire logic rst_i,
    input wire logic en_v2t_i,
    input wire logic en_slice_i,
    input wire logic strobe_i,
    input wire logic en_sync_i,            // token from the previous slice
    input acore_pkg::offset_t offset_i,
    input acore_pkg::sample_t rx_in_i,
    output logic en_sync_o,                // token to the next slice
    output acore_pkg::code_t adder_out_o,
    output logic sign_out_o,
    output logic done_o
);

    localparam int VW = `ACORE_NIN + 1;
    localparam int CODE_MAX = (1 << `ACORE_NADC) - 1;

    logic token_q;
    logic samp_v_q;
    acore_pkg::sample_t samp_q;
    logic [VW-1:0] sum;
    logic [VW-1:0] mag;
    acore_pkg::code_t code_sat;

    // hand off the token on our strobe
    assign en_sync_o = strobe_i & token_q;

    always_ff @(posedge ext_clk) begin
        if (rst_i) begin
            token_q  <= FIRST_SLICE;
            samp_v_q <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            if (!en_v2t_i) begin
                token_q <= FIRST_SLICE;            // chain restarts at slice 0
            end else begin
                token_q <= (token_q & ~strobe_i) | en_sync_i;
            end
            samp_v_q <= en_sync_o;
            done_o   <= samp_v_q;
        end
    end

    // sample register
    always_ff @(posedge ext_clk) begin
        if (en_sync_o) begin
            samp_q <= rx_in_i;
        end
    end

    // sign extended sum of sample and trim
    assign sum = {samp_q[`ACORE_NIN-1], samp_q} + {offset_i[`ACORE_NIN-1], offset_i};
    assign mag = sum[VW-1] ? (~sum + 1'b1) : sum;  // -256 comes out as 256 unsigned

    assign code_sat = (mag > VW'(CODE_MAX)) ? acore_pkg::code_t'(CODE_MAX)
                                            : mag[`ACORE_NADC-1:0];

    always_ff @(posedge ext_clk) begin
        if (samp_v_q) begin
            adder_out_o <= en_slice_i ? code_sat : '0;
            sign_out_o  <= en_slice_i & ~sum[VW-1];   // zero counts as positive
        end
    end

endmodule

/* analog_core.sv */
`include "acore_cfg.svh"

module analog_core (
    input wire logic ext_clk,
    input wire logic rst_i,

    // apb slave
    input wire logic psel_i,
    input wire logic penable_i,
    input wire logic pwrite_i,
    input acore_pkg::paddr_t paddr_i,
    input acore_pkg::pdata_t pwdata_i,
    output acore_pkg::pdata_t prdata_o,
    output logic pready_o,
    output logic pslverr_o,

    input acore_pkg::sample_t rx_in_i,

    output logic [`ACORE_NTI*`ACORE_NADC-1:0] adder_out_o,  // slice 0 in the low byte
    output logic [`ACORE_NTI-1:0] sign_out_o,
    output logic frame_valid_o
);

    logic en_v2t;
    logic [`ACORE_NTI-1:0] en_slice;
    acore_pkg::ndiv_t ndiv;
    logic [`ACORE_NTI*`ACORE_NIN-1:0] offset;
    acore_pkg::fcount_t frame_count;
    logic strobe;

    logic [`ACORE_NTI-1:0] en_sync;
    logic [`ACORE_NTI*`ACORE_NADC-1:0] slice_code;
    logic [`ACORE_NTI-1:0] slice_sign;
    logic [`ACORE_NTI-1:0] slice_done;

    acore_apb_regs i_regs (
        .ext_clk(ext_clk),
        .rst_i(rst_i),
        .psel_i(psel_i),
        .penable_i(penable_i),
        .pwrite_i(pwrite_i),
        .paddr_i(paddr_i),
        .pwdata_i(pwdata_i),
        .prdata_o(prdata_o),
        .pready_o(pready_o),
        .pslverr_o(pslverr_o),
        .frame_count_i(frame_count),
        .en_v2t_o(en_v2t),
        .en_slice_o(en_slice),
        .ndiv_o(ndiv),
        .offset_o(offset)
    );

    // sample strobe
    input_divider i_indiv (
        .ext_clk(ext_clk),
        .rst_i(rst_i),
        .en_i(en_v2t),
        .ndiv_i(ndiv),
        .strobe_o(strobe)
    );

    // interleaved slices, token ring closes from the last slice back to slice 0
    for (genvar k = 0; k < `ACORE_NTI; k++) begin : g_adc
        adc_slice #(
            .FIRST_SLICE(k == 0)
        ) i_adc (
            .ext_clk(ext_clk),
            .rst_i(rst_i),
            .en_v2t_i(en_v2t),
            .en_slice_i(en_slice[k]),
            .strobe_i(strobe),
            .en_sync_i(en_sync[(k + `ACORE_NTI - 1) % `ACORE_NTI]),
            .offset_i(offset[k*`ACORE_NIN +: `ACORE_NIN]),
            .rx_in_i(rx_in_i),
            .en_sync_o(en_sync[k]),
            .adder_out_o(slice_code[k*`ACORE_NADC +: `ACORE_NADC]),
            .sign_out_o(slice_sign[k]),
            .done_o(slice_done[k])
        );
    end

    frame_retimer i_retimer (
        .ext_clk(ext_clk),
        .rst_i(rst_i),
        .codes_i(slice_code),
        .signs_i(slice_sign),
        .last_done_i(slice_done[`ACORE_NTI-1]),
        .adder_out_o(adder_out_o),
        .sign_out_o(sign_out_o),
        .frame_valid_o(frame_valid_o),
        .frame_count_o(frame_count)
    );

endmodule

/* files.f */
+incdir+.
acore_pkg.sv
acore_apb_regs.sv
input_divider.sv
adc_slice.sv
frame_retimer.sv
analog_core.sv
tb_analog_core.sv

/* frame_retimer.sv */
`include "acore_cfg.svh"

module frame_retimer (
    input wire logic ext_clk,
    input wire logic rst_i,
    input wire logic [`ACORE_NTI*`ACORE_NADC-1:0] codes_i,
    input wire logic [`ACORE_NTI-1:0] signs_i,
    input wire logic last_done_i,          // done of the last slice closes a frame
    output logic [`ACORE_NTI*`ACORE_NADC-1:0] adder_out_o,
    output logic [`ACORE_NTI-1:0] sign_out_o,
    output logic frame_valid_o,
    output acore_pkg::fcount_t frame_count_o
);

    // frame data, held until the next frame
    always_ff @(posedge ext_clk) begin
        if (last_done_i) begin
            adder_out_o <= codes_i;
            sign_out_o  <= signs_i;
        end
    end

    always_ff @(posedge ext_clk) begin
        if (rst_i) begin
            frame_valid_o <= 1'b0;
            frame_count_o <= '0;
        end else begin
            frame_valid_o <= last_done_i;
            if (last_done_i) begin
                frame_count_o <= frame_count_o + 1'b1;   // wraps
            end
        end
    end

endmodule

/* input_divider.sv */
module input_divider (
    input wire logic ext_clk,
    input wire logic rst_i,
    input wire logic en_i,
    input acore_pkg::ndiv_t ndiv_i,
    output logic strobe_o                  // one cycle wide, shared by all slices
);

    acore_pkg::ndiv_t cnt_q;

    // strobe on the last count of each period
    assign strobe_o = en_i & (cnt_q == ndiv_i);

    always_ff @(posedge ext_clk) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (!en_i) begin
            cnt_q <= '0;                   // held so the first period is a full one
        end else if (strobe_o) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass message
verilator --binary -f files.f --top-module tb_analog_core -o sim_tb \
    && ./obj_dir/sim_tb | grep "TESTBENCH PASSED" \
    || exit 1

/* tb_analog_core.sv */
`include "acore_cfg.svh"

module tb_analog_core;

    localparam logic [7:0] A_CTRL = 8'h00;
    localparam logic [7:0] A_NDIV = 8'h04;
    localparam logic [7:0] A_OFS0 = 8'h08;
    localparam logic [7:0] A_STATUS = 8'h18;

    logic ext_clk;
    logic rst_i;
    logic psel_i;
    logic penable_i;
    logic pwrite_i;
    acore_pkg::paddr_t paddr_i;
    acore_pkg::pdata_t pwdata_i;
    acore_pkg::pdata_t prdata_o;
    logic pready_o;
    logic pslverr_o;
    acore_pkg::sample_t rx_in_i;
    logic [`ACORE_NTI*`ACORE_NADC-1:0] adder_out_o;
    logic [`ACORE_NTI-1:0] sign_out_o;
    logic frame_valid_o;

    int errors;
    int checks;
    int cyc;                    // rising edges so far
    int frames_prev;            // frames of earlier enable runs
    int en_edge;                // access edge that set en_v2t
    int en_stop;                // access edge that cleared en_v2t
    int per_run;                // strobe period of the current run
    longint limit;
    logic en_m;
    logic [3:0] mask_m;
    int ndiv_m;
    logic [7:0] ofs_m [4];

    analog_core i_dut (
        .ext_clk(ext_clk),
        .rst_i(rst_i),
        .psel_i(psel_i),
        .penable_i(penable_i),
        .pwrite_i(pwrite_i),
        .paddr_i(paddr_i),
        .pwdata_i(pwdata_i),
        .prdata_o(prdata_o),
        .pready_o(pready_o),
        .pslverr_o(pslverr_o),
        .rx_in_i(rx_in_i),
        .adder_out_o(adder_out_o),
        .sign_out_o(sign_out_o),
        .frame_valid_o(frame_valid_o)
    );

    always #20 ext_clk = ~ext_clk;

    always @(posedge ext_clk) cyc <= cyc + 1;

    task automatic next_cycle;
        @(posedge ext_clk);
        #2;
    endtask

    task automatic report_mismatch(string name, longint exp, longint act);
        errors++;
        $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, act);
    endtask

    // sign in bit 8, capped magnitude below
    function automatic logic [8:0] slice_model(logic [7:0] x, logic [7:0] ofs, logic en);
        int v;
        int mag;
        v = int'($signed(x)) + int'($signed(ofs));
        mag = (v < 0) ? -v : v;
        if (mag > 255) mag = 255;
        if (!en) return 9'd0;
        return {v >= 0, 8'(mag)};
    endfunction

    // one frame per fourth strobe, counted 2 edges after that strobe
    function automatic int frames_expected(int now);
        int span;
        int n;
        span = now - 2 - en_edge;
        if (!en_m && en_stop - en_edge < span) span = en_stop - en_edge;
        n = frames_prev;
        if (span > 0) n += span / (4 * per_run);
        return n;
    endfunction

    task automatic apb_write(logic [7:0] addr, logic [31:0] data);
        logic err;
        logic rdy;
        logic exp_err;
        psel_i = 1'b1;
        penable_i = 1'b0;
        pwrite_i = 1'b1;
        paddr_i = addr;
        pwdata_i = data;
        next_cycle();
        penable_i = 1'b1;
        @(negedge ext_clk);
        err = pslverr_o;
        rdy = pready_o;
        next_cycle();                          // cyc now holds the access edge
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        exp_err = !(addr <= A_STATUS && addr[1:0] == 2'b00) || addr == A_STATUS;
        checks += 2;
        if (err !== exp_err) report_mismatch("pslverr_o", 64'(exp_err), 64'(err));
        if (rdy !== 1'b1) report_mismatch("pready_o", 1, 64'(rdy));
        if (!exp_err) begin
            if (addr == A_CTRL) begin
                if (!en_m && data[0]) begin
                    frames_prev += (en_stop - en_edge) / (4 * per_run);  // close last run
                    en_edge = cyc;
                    per_run = ndiv_m + 1;
                end
                if (en_m && !data[0]) en_stop = cyc;
                en_m = data[0];
                mask_m = data[7:4];
            end else if (addr == A_NDIV) begin
                ndiv_m = int'(data[3:0]);
            end else if (addr >= A_OFS0 && addr < A_STATUS) begin
                ofs_m[(addr - A_OFS0) >> 2] = data[7:0];
            end
        end
    endtask

    task automatic apb_read(logic [7:0] addr, logic [31:0] exp_data, logic exp_err);
        logic [31:0] data;
        logic err;
        psel_i = 1'b1;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = addr;
        next_cycle();
        penable_i = 1'b1;
        @(negedge ext_clk);
        data = prdata_o;
        err = pslverr_o;
        if (addr == A_STATUS) exp_data = 32'(frames_expected(cyc));  // from strobe timing
        checks += 2;
        if (data !== exp_data) report_mismatch("prdata_o", 64'(exp_data), 64'(data));
        if (err !== exp_err) report_mismatch("pslverr_o", 64'(exp_err), 64'(err));
        next_cycle();
        psel_i = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic run_frame(logic [7:0] x [4]);
        int p;
        int j;
        int s3;
        int t;
        logic found;
        logic [8:0] m;
        p = ndiv_m + 1;
        if (!en_m) begin
            errors++;
            $display("sample group given while en_v2t is clear");
            return;
        end
        j = (cyc + 1 - en_edge + p - 1) / p;
        if (j < 1) j = 1;
        while (j % 4 != 1) j++;                 // next strobe that lands on slice 0
        for (int k = 0; k < 4; k++) begin
            while (cyc < en_edge + p * (j + k) - 1) next_cycle();
            rx_in_i = x[k];                     // held across slice k's strobe edge
        end
        s3 = en_edge + p * (j + 3);
        t = 0;
        found = 1'b0;
        while (!found && t < 4 * p + 4) begin
            @(negedge ext_clk);
            if (cyc >= s3 && frame_valid_o) found = 1'b1;
            else t++;
        end
        if (!found) begin
            errors++;
            $display("no frame_valid_o within %0d cycles of the sample group", 4 * p + 4);
        end else begin
            checks++;
            if (cyc != s3 + 2) report_mismatch("frame_valid_o edge", s3 + 2, cyc);
            for (int k = 0; k < 4; k++) begin
                m = slice_model(x[k], ofs_m[k], mask_m[k]);
                checks += 2;
                if (adder_out_o[8*k +: 8] !== m[7:0])
                    report_mismatch($sformatf("adder_out_o[%0d]", k), m[7:0],
                                    adder_out_o[8*k +: 8]);
                if (sign_out_o[k] !== m[8])
                    report_mismatch($sformatf("sign_out_o[%0d]", k), m[8], sign_out_o[k]);
            end
        end
        next_cycle();
    endtask

    initial begin
        int fd;
        int rc;
        int nlines;
        string line;
        logic [7:0] cmd;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        logic [7:0] x [4];
        ext_clk = 1'b0;
        rst_i = 1'b1;
        psel_i = 1'b0;
        penable_i = 1'b0;
        pwrite_i = 1'b0;
        paddr_i = '0;
        pwdata_i = '0;
        rx_in_i = '0;
        errors = 0;
        checks = 0;
        cyc = 0;
        frames_prev = 0;
        en_edge = 0;
        en_stop = 0;
        per_run = 1;
        limit = 0;
        en_m = 1'b0;
        mask_m = '0;
        ndiv_m = 0;
        for (int k = 0; k < 4; k++) ofs_m[k] = '0;
        repeat (4) @(posedge ext_clk);
        #2;
        rst_i = 1'b0;
        checks++;
        if (frame_valid_o !== 1'b0) report_mismatch("frame_valid_o", 0, 64'(frame_valid_o));
        fd = $fopen("acore_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open acore_tests.txt");
        end else begin
            nlines = 0;
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0) nlines++;
            end
            $fclose(fd);
            limit = longint'(nlines) * (4 * 16 + 10) * 40;
            fd = $fopen("acore_tests.txt", "r");
            while ($fscanf(fd, " %c", cmd) == 1) begin
                case (cmd)
                    "#": rc = $fgets(line, fd);
                    "W": begin
                        rc = $fscanf(fd, " %h %h", a, d);
                        apb_write(a[7:0], d);
                    end
                    "R": begin
                        rc = $fscanf(fd, " %h %h %h", a, d, e);
                        apb_read(a[7:0], d, e[0]);
                    end
                    "F": begin
                        rc = $fscanf(fd, " %h %h %h %h", x[0], x[1], x[2], x[3]);
                        run_frame(x);
                    end
                    default: begin
                        errors++;
                        $display("unknown command in acore_tests.txt");
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("errors: %0d checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog scaled by the number of test lines
    initial begin
        wait (limit > 0);
        #(limit);
        $display("timeout, the test file did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
